//--- verilog.f
+incdir+hdl
hdl/nnPkg.sv
hdl/cfgIf.sv
hdl/weightBank.sv
hdl/reluQuantizer.sv
hdl/neuronUnit.sv
hdl/layerSequencer.sv
hdl/nnLayer.sv
dv/clockGen.sv
dv/tbNnLayer.sv

//--- Makefile
VERILATOR ?= verilator
FILELIST ?= verilog.f
TB_TOP ?= tbNnLayer
RTL_TOP ?= nnLayer
BUILD_DIR ?= obj_dir
LOG ?= sim.log
PASS_MSG ?= all tests passed
LINT_FLAGS ?= --lint-only --timing
SIM_FLAGS ?= --binary --timing --assert -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TB_TOP) | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- dv/tbNnLayer.sv
`timescale 1ns/10ps
`default_nettype none

`include "nn_config.svh"

module tbNnLayer;

	localparam int CycleLimit = 2000; // well above the length of all tests
	localparam int RefWeights [`NN_NUM_INPUTS] =
		'{31, 3, 11, -22, 3, 18, -31, -31, -31, 25, 6, 5, 0, -14, 15};
	// negative, saturated, large, rounds past the ceiling, exact half, just above half
	localparam int EdgeBiases [6] = '{-100, 8192, 20000, 8191, 352, 353};

	logic clk;
	logic reset;
	logic sampleValid;
	logic [`NN_NUM_INPUTS*8-1:0] activations;
	logic cfgWrite;
	nnPkg::cfgTarget_t cfgTarget;
	nnPkg::neuronSel_t cfgNeuron;
	nnPkg::inputSel_t cfgIndex;
	nnPkg::cfgData_t cfgData;
	logic resultValid;
	logic [`NN_NUM_NEURONS*8-1:0] results;
	logic cfgDropped;
	logic [15:0] sampleCount;

	int modelW [`NN_NUM_NEURONS][`NN_NUM_INPUTS];
	int modelB [`NN_NUM_NEURONS];
	logic [`NN_NUM_NEURONS*8-1:0] expFifo [256]; // expected results in sample order
	logic [`NN_NUM_NEURONS*8-1:0] headExp;
	logic [7:0] pushPtr;
	logic [7:0] popPtr;
	logic prevValid; // sampleValid as driven in the previous cycle
	int samplesSent;
	int cycles = 0;
	int valueErrors;
	int otherErrors;
	string testName;

	clockGen uClock (.clk(clk), .reset(reset));

	nnLayer u_dut
	(
		.clk(clk),
		.reset(reset),
		.sampleValid(sampleValid),
		.activations(activations),
		.cfgWrite(cfgWrite),
		.cfgTarget(cfgTarget),
		.cfgNeuron(cfgNeuron),
		.cfgIndex(cfgIndex),
		.cfgData(cfgData),
		.resultValid(resultValid),
		.results(results),
		.cfgDropped(cfgDropped),
		.sampleCount(sampleCount)
	);

	// rectify, then round with an exact half going down, then saturate
	function automatic logic [`NN_NUM_NEURONS*8-1:0] expectedLayer(input int a [`NN_NUM_INPUTS]);
		logic [`NN_NUM_NEURONS*8-1:0] word;
		int sum;
		int q;
		for (int n = 0; n < `NN_NUM_NEURONS; n++)
		begin
			sum = modelB[n];
			for (int i = 0; i < `NN_NUM_INPUTS; i++)
				sum = sum + a[i] * modelW[n][i];
			if (sum < 0)
				q = 0;
			else if (sum >= ((`NN_OUT_MAX + 1) << `NN_FRAC_SHIFT))
				q = `NN_OUT_MAX;
			else
			begin
				q = sum >> `NN_FRAC_SHIFT;
				if ((sum % (1 << `NN_FRAC_SHIFT)) > (1 << (`NN_FRAC_SHIFT - 1)))
					q++;
				if (q > `NN_OUT_MAX)
					q = `NN_OUT_MAX;
			end
			word[n*8 +: 8] = 8'(q);
		end
		return word;
	endfunction

	task automatic reportValue(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		valueErrors++;
		$display("ERROR %s: %s expected %0h, actual %0h", testName, what, expected, actual);
	endtask

	task automatic reportOther(input string what);
		otherErrors++;
		$display("test %s failed: %s", testName, what);
	endtask

	task automatic tick();
		@(posedge clk);
		prevValid = sampleValid;
		#2;
		sampleValid = 1'b0;
		cfgWrite = 1'b0;
	endtask

	task automatic fillRandom(output int a [`NN_NUM_INPUTS]);
		for (int i = 0; i < `NN_NUM_INPUTS; i++)
			a[i] = int'($urandom_range(255)) - 128;
	endtask

	task automatic driveSample(input int a [`NN_NUM_INPUTS]);
		sampleValid = 1'b1;
		for (int i = 0; i < `NN_NUM_INPUTS; i++)
			activations[i*8 +: 8] = 8'(a[i]);
		expFifo[pushPtr] = expectedLayer(a);
		pushPtr = pushPtr + 8'd1;
		samplesSent++;
	endtask

	// the model only follows writes that no sample in flight can block
	task automatic driveWrite(input nnPkg::cfgTarget_t target, input int neuron, input int index,
		input int value);
		cfgWrite = 1'b1;
		cfgTarget = target;
		cfgNeuron = nnPkg::neuronSel_t'(neuron);
		cfgIndex = nnPkg::inputSel_t'(index);
		cfgData = nnPkg::cfgData_t'(value);
		if (!sampleValid && !prevValid)
		begin
			if (target == nnPkg::TARGET_BIAS)
				modelB[neuron] = int'($signed(16'(value)));
			else
				modelW[neuron][index] = int'($signed(8'(value)));
		end
	endtask

	assign headExp = expFifo[popPtr];

	always @(posedge clk)
	begin
		if (reset)
			popPtr <= '0;
		else if (resultValid)
			popPtr <= popPtr + 8'd1;
	end

	resetState: assert property (@(posedge clk)
		$fell(reset) |-> !resultValid && !cfgDropped && sampleCount == 16'd0)
		else reportOther("outputs were not cleared by reset");
	validTiming: assert property (@(posedge clk) disable iff (reset)
		resultValid == $past(sampleValid, 3))
		else reportValue("resultValid", !$sampled(resultValid), $sampled(resultValid));
	dropTiming: assert property (@(posedge clk) disable iff (reset)
		cfgDropped == ($past(cfgWrite) && ($past(sampleValid) || $past(sampleValid, 2))))
		else reportValue("cfgDropped", !$sampled(cfgDropped), $sampled(cfgDropped));
	resultOwner: assert property (@(posedge clk) disable iff (reset)
		resultValid |-> pushPtr != popPtr)
		else reportOther("result valid with no sample outstanding");
	resultValue: assert property (@(posedge clk) disable iff (reset)
		resultValid |-> results == headExp)
		else reportValue("results", $sampled(headExp), $sampled(results));

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= CycleLimit)
		begin
			$display("timeout after %0d cycles, the run was stopped", cycles);
			$display("tests failed");
			$finish;
		end
	end

	initial
	begin
		int act [`NN_NUM_INPUTS];
		void'($urandom(21));
		sampleValid = 1'b0;
		activations = '0;
		cfgWrite = 1'b0;
		cfgTarget = nnPkg::TARGET_WEIGHT;
		cfgNeuron = '0;
		cfgIndex = '0;
		cfgData = '0;
		prevValid = 1'b0;
		pushPtr = '0;
		samplesSent = 0;
		valueErrors = 0;
		otherErrors = 0;
		modelW = '{default: '{default: 0}};
		modelB = '{default: 0};
		testName = "reset";
		@(negedge reset);

		fillRandom(act); // weights are still cleared, so every output is zero
		driveSample(act);
		tick();
		tick();

		testName = "reference";
		for (int n = 0; n < `NN_NUM_NEURONS; n++)
		begin
			for (int i = 0; i < `NN_NUM_INPUTS; i++)
			begin
				driveWrite(nnPkg::TARGET_WEIGHT, n, i,
					(n == 0) ? RefWeights[i] : int'($urandom_range(255)) - 128);
				tick();
			end
			driveWrite(nnPkg::TARGET_BIAS, n, 0, (n == 0) ? 0 : int'($urandom_range(4000)) - 2000);
			tick();
		end
		for (int s = 0; s < 100; s++)
		begin
			fillRandom(act);
			driveSample(act);
			tick();
			if ($urandom_range(1) == 1)
				tick();
		end
		tick();

		testName = "edges";
		act = '{default: 0}; // with zero inputs the sum is the bias alone
		for (int k = 0; k < 6; k++)
		begin
			driveWrite(nnPkg::TARGET_BIAS, 1, 0, EdgeBiases[k]);
			tick();
			driveSample(act);
			tick();
			tick();
		end

		testName = "back to back";
		repeat (8)
		begin
			fillRandom(act);
			driveSample(act);
			tick();
		end
		tick();
		tick();

		testName = "write gating";
		act = '{default: 0};
		act[0] = 100; // the sum is the bias plus a hundred times weight 0
		driveSample(act);
		driveWrite(nnPkg::TARGET_WEIGHT, 0, 0, -77); // collides with the sample
		tick();
		driveWrite(nnPkg::TARGET_WEIGHT, 0, 0, -77); // sample sits in stage 1
		tick();
		driveSample(act); // the dropped writes left the old weight in place
		tick();
		tick();
		driveWrite(nnPkg::TARGET_WEIGHT, 0, 0, -77);
		tick();
		driveSample(act);
		tick();

		testName = "sample count";
		while (pushPtr != popPtr)
			tick();
		tick();
		countCheck: assert (sampleCount == 16'(samplesSent))
			else reportValue("sampleCount", samplesSent, sampleCount);

		$display("errors: %0d value mismatches, %0d other failures", valueErrors, otherErrors);
		if (valueErrors + otherErrors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- dv/clockGen.sv
`timescale 1ns/10ps
`default_nettype none

module clockGen
(
	output logic clk,
	output logic reset
);

	localparam int HalfPeriod = 10; // 20 ns clock
	localparam int ResetCycles = 2;

	initial
	begin
		clk = 1'b0;
		forever #(HalfPeriod) clk = ~clk;
	end

	initial
	begin
		reset = 1'b1;
		repeat (ResetCycles) @(posedge clk);
		#2 reset = 1'b0; // released with the same offset as the other inputs
	end

endmodule

`default_nettype wire

//--- hdl/nnLayer.sv
`timescale 1ns/10ps
`default_nettype none

`include "nn_config.svh"

module nnLayer
(
	input wire logic clk,
	input wire logic reset,
	input wire logic sampleValid,
	input wire logic [`NN_NUM_INPUTS*8-1:0] activations, // input 0 in the low byte
	input wire logic cfgWrite,
	input nnPkg::cfgTarget_t cfgTarget,
	input nnPkg::neuronSel_t cfgNeuron,
	input nnPkg::inputSel_t cfgIndex,
	input nnPkg::cfgData_t cfgData,
	output logic resultValid,
	output logic [`NN_NUM_NEURONS*8-1:0] results, // neuron 0 in the low byte
	output logic cfgDropped,
	output logic [15:0] sampleCount
);

	localparam int ActWidth = $bits(nnPkg::activation_t);
	localparam int ResWidth = $bits(nnPkg::result_t);

	nnPkg::activation_t actArray [`NN_NUM_INPUTS];
	nnPkg::weight_t weights [`NN_NUM_NEURONS][`NN_NUM_INPUTS];
	nnPkg::bias_t biases [`NN_NUM_NEURONS];
	nnPkg::result_t resultArray [`NN_NUM_NEURONS];

	cfgIf cfgBus ();

	for (genvar i = 0; i < `NN_NUM_INPUTS; i++)
	begin : genUnpack
		assign actArray[i] = nnPkg::activation_t'(activations[i*ActWidth +: ActWidth]);
	end

	layerSequencer uSequencer
	(
		.clk(clk),
		.reset(reset),
		.sampleValid(sampleValid),
		.cfgWrite(cfgWrite),
		.cfgTarget(cfgTarget),
		.cfgNeuron(cfgNeuron),
		.cfgIndex(cfgIndex),
		.cfgData(cfgData),
		.cfg(cfgBus.sequencer),
		.resultValid(resultValid),
		.cfgDropped(cfgDropped),
		.sampleCount(sampleCount)
	);

	weightBank uBank
	(
		.clk(clk),
		.reset(reset),
		.cfg(cfgBus.bank),
		.weights(weights),
		.biases(biases)
	);

	for (genvar n = 0; n < `NN_NUM_NEURONS; n++)
	begin : genNeuron
		neuronUnit uNeuron
		(
			.clk(clk),
			.reset(reset),
			.activations(actArray),
			.weights(weights[n]),
			.bias(biases[n]),
			.result(resultArray[n])
		);

		assign results[n*ResWidth +: ResWidth] = resultArray[n];
	end

endmodule

`default_nettype wire

//--- hdl/layerSequencer.sv
`timescale 1ns/10ps
`default_nettype none

module layerSequencer
(
	input wire logic clk,
	input wire logic reset,
	input wire logic sampleValid,
	input wire logic cfgWrite,
	input nnPkg::cfgTarget_t cfgTarget,
	input nnPkg::neuronSel_t cfgNeuron,
	input nnPkg::inputSel_t cfgIndex,
	input nnPkg::cfgData_t cfgData,
	cfgIf.sequencer cfg,
	output logic resultValid,
	output logic cfgDropped,
	output logic [15:0] sampleCount
);

	logic [2:0] validPipe; // bit 0 is stage 1, bit 2 lines up with the neuron results
	logic writeBlocked;

	// the sample arriving now and the one in stage 1 still need the current weights
	assign writeBlocked = sampleValid || validPipe[0];

	assign cfg.wrEn = cfgWrite && !writeBlocked;
	assign cfg.target = cfgTarget;
	assign cfg.neuron = cfgNeuron;
	assign cfg.index = cfgIndex;
	assign cfg.data = cfgData;

	assign resultValid = validPipe[2];

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			validPipe <= '0;
			cfgDropped <= 1'b0;
			sampleCount <= '0;
		end
		else
		begin
			validPipe <= {validPipe[1:0], sampleValid};
			cfgDropped <= cfgWrite && writeBlocked;
			if (validPipe[2])
				sampleCount <= sampleCount + 16'd1;
		end
	end

endmodule

`default_nettype wire

//--- hdl/neuronUnit.sv
`timescale 1ns/10ps
`default_nettype none

`include "nn_config.svh"

module neuronUnit
(
	input wire logic clk,
	input wire logic reset,
	input nnPkg::activation_t activations [`NN_NUM_INPUTS],
	input nnPkg::weight_t weights [`NN_NUM_INPUTS],
	input nnPkg::bias_t bias,
	output nnPkg::result_t result
);

	nnPkg::activation_t actReg [`NN_NUM_INPUTS];
	nnPkg::accum_t products [`NN_NUM_INPUTS];
	nnPkg::accum_t sumNext;
	nnPkg::accum_t accReg;
	nnPkg::result_t quantized;

	// operands are widened first so the products keep their sign
	always_comb
	begin
		for (int i = 0; i < `NN_NUM_INPUTS; i++)
			products[i] = nnPkg::accum_t'(actReg[i]) * nnPkg::accum_t'(weights[i]);
	end

	always_comb
	begin
		sumNext = nnPkg::accum_t'(bias);
		for (int i = 0; i < `NN_NUM_INPUTS; i++)
			sumNext = sumNext + products[i];
	end

	reluQuantizer uQuant
	(
		.sum(accReg),
		.result(quantized)
	);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < `NN_NUM_INPUTS; i++)
				actReg[i] <= '0;
			accReg <= '0;
			result <= '0;
		end
		else
		begin
			actReg <= activations; // stage 1
			accReg <= sumNext; // stage 2 reads the bank as it stands now
			result <= quantized; // stage 3
		end
	end

endmodule

`default_nettype wire

//--- hdl/reluQuantizer.sv
`timescale 1ns/10ps
`default_nettype none

`include "nn_config.svh"

module reluQuantizer
(
	input nnPkg::accum_t sum,
	output nnPkg::result_t result
);

	localparam int FracShift = `NN_FRAC_SHIFT;
	localparam nnPkg::accum_t OutMax = nnPkg::accum_t'(`NN_OUT_MAX);
	localparam nnPkg::accum_t SatLimit = nnPkg::accum_t'((`NN_OUT_MAX + 1) << `NN_FRAC_SHIFT);

	logic roundUp;
	nnPkg::accum_t truncated;
	nnPkg::accum_t rounded;

	// an exact half rounds down, anything above it rounds up
	assign roundUp = sum[FracShift-1] && (sum[FracShift-2:0] != '0);
	assign truncated = sum >>> FracShift;
	assign rounded = truncated + nnPkg::accum_t'(roundUp);

	always_comb
	begin
		if (sum < 0)
			result = '0; // rectify
		else if (sum >= SatLimit || rounded > OutMax)
			result = nnPkg::result_t'(OutMax);
		else
			result = nnPkg::result_t'(rounded);
	end

endmodule

`default_nettype wire

//--- hdl/weightBank.sv
`timescale 1ns/10ps
`default_nettype none

`include "nn_config.svh"

module weightBank
(
	input wire logic clk,
	input wire logic reset,
	cfgIf.bank cfg,
	output nnPkg::weight_t weights [`NN_NUM_NEURONS][`NN_NUM_INPUTS],
	output nnPkg::bias_t biases [`NN_NUM_NEURONS]
);

	logic weightWrite;
	logic biasWrite;

	assign weightWrite = cfg.wrEn && (cfg.target == nnPkg::TARGET_WEIGHT);
	assign biasWrite = cfg.wrEn && (cfg.target == nnPkg::TARGET_BIAS);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int n = 0; n < `NN_NUM_NEURONS; n++)
			begin
				biases[n] <= '0;
				for (int i = 0; i < `NN_NUM_INPUTS; i++)
					weights[n][i] <= '0;
			end
		end
		else
		begin
			// an index or neuron number past the end matches nothing
			for (int n = 0; n < `NN_NUM_NEURONS; n++)
			begin
				if (cfg.neuron == nnPkg::neuronSel_t'(n))
				begin
					if (biasWrite)
						biases[n] <= nnPkg::bias_t'(cfg.data);
					for (int i = 0; i < `NN_NUM_INPUTS; i++)
					begin
						if (weightWrite && cfg.index == nnPkg::inputSel_t'(i))
							weights[n][i] <= nnPkg::weight_t'(cfg.data[7:0]);
					end
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- hdl/cfgIf.sv
`timescale 1ns/10ps
`default_nettype none

interface cfgIf;

	logic wrEn; // one-cycle strobe, the bank writes on this edge
	nnPkg::cfgTarget_t target;
	nnPkg::neuronSel_t neuron;
	nnPkg::inputSel_t index; // ignored for bias writes
	nnPkg::cfgData_t data; // a weight uses the low byte only

	modport sequencer
	(
		output wrEn, target, neuron, index, data
	);

	modport bank
	(
		input wrEn, target, neuron, index, data
	);

endinterface

`default_nettype wire

//--- hdl/nnPkg.sv
`default_nettype none

`include "nn_config.svh"

package nnPkg;

	typedef logic signed [7:0] activation_t;
	typedef logic signed [7:0] weight_t;
	typedef logic signed [15:0] bias_t;
	typedef logic signed [22:0] accum_t; // fifteen products plus bias cannot overflow this
	typedef logic [7:0] result_t;

	// configuration write fields
	typedef logic [$clog2(`NN_NUM_NEURONS)-1:0] neuronSel_t;
	typedef logic [$clog2(`NN_NUM_INPUTS)-1:0] inputSel_t;
	typedef logic [15:0] cfgData_t;

	typedef enum logic
	{
		TARGET_WEIGHT = 1'b0,
		TARGET_BIAS = 1'b1
	} cfgTarget_t;

endpackage

`default_nettype wire

//--- hdl/nn_config.svh
`ifndef NN_CONFIG_SVH
`define NN_CONFIG_SVH

// layer shape
`define NN_NUM_NEURONS 4 // neurons in the layer
`define NN_NUM_INPUTS 15 // activations per sample

// activation quantization
`define NN_FRAC_SHIFT 6 // accumulator fraction bits dropped by the activation
`define NN_OUT_MAX 127 // ceiling of a neuron output

`endif
